// ==== dv/fifo_flags_tests.txt ====
# fifo flag controller tests, one test per line, run in order
# columns: op count write_address read_address error_pulses
# op is reset, fill, overflow, drain, underflow or random
# for reset the count is the number of cycles reset is held
# otherwise the count is the number of cycles in the burst
# an expected value of -1 is left to the occupancy model alone
reset      2  0  0  0
fill       7  0  0  0
overflow   3  0  0  3
drain      7  0  0  0
underflow  2  0  0  2
fill       3  3  0  0
drain      2  3  2  0
fill       6  2  2  0
overflow   1  2  2  1
drain      7  2  2  0
underflow  1  2  2  1
fill       5  0  2  0
drain      5  0  0  0
fill       4  4  0  0
fill       3  0  0  0
overflow   4  0  0  4
drain      1  0  1  0
fill       1  1  1  0
overflow   2  1  1  2
drain      6  1  0  0
drain      1  1  1  0
underflow  3  1  1  3
reset      2  0  0  0
fill       2  2  0  0
drain      2  2  2  0
underflow  1  2  2  1
random   200 -1 -1 -1
reset      2  0  0  0
fill       7  0  0  0
overflow   1  0  0  1
drain      7  0  0  0
underflow  1  0  0  1

// ==== src.f ====
hdl/fifo_flags_pkg.sv
hdl/write_flag_ctrl.sv
hdl/pointer_sync.sv
hdl/read_flag_ctrl.sv
hdl/fifo_flags_top.sv
dv/fifo_flags_tb.sv

// ==== Makefile ====
# Verilator build and run of the fifo flag controller testbench

VERILATOR ?= verilator
TOP       ?= fifo_flags_tb
LOG       ?= sim.log
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "failure reported, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "no pass result found, see $(LOG)"; exit 1; \
	fi
	@echo "run finished cleanly, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/fifo_flags_tb.sv ====
// testbench for the fifo flag controller: runs the tests of the data file against an occupancy model
module fifo_flags_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [8*16-1:0] name_t;
  typedef enum int {
    OP_RESET,
    OP_FILL,
    OP_OVERFLOW,
    OP_DRAIN,
    OP_UNDERFLOW,
    OP_RANDOM,
    OP_UNKNOWN
  } op_kind_t;

  // DUT connections
  logic read_clk;
  logic reset_flags_async;
  logic write_submit;
  logic read_remove;
  logic write_capture_data;
  logic write_room_available;
  logic write_error;
  logic read_data_available;
  logic read_error;
  fifo_flags_pkg::fifo_addr_t write_address;
  fifo_flags_pkg::fifo_addr_t read_address;

  // occupancy model, counts of accepted writes and removes since reset
  int wr_total = 0;
  int rd_total = 0;
  // a refused request in one cycle must show as an error pulse in the next
  logic pending_write_error = 1'b0;
  logic pending_read_error = 1'b0;
  // flags seen at the latest mid-cycle sample
  logic sampled_room = 1'b0;
  logic sampled_data = 1'b0;
  int error_count = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_passed = 0;
  bit timed_out = 1'b0;
  int wait_limit = 20;
  integer seed = 32'h82a5ef11;
  name_t current_test = '0;

  // ============================================================
  // clock and DUT
  // ============================================================

  initial
  begin
    read_clk = 1'b0;
    forever #20 read_clk = ~read_clk;
  end

  fifo_flags_top u_dut (
    .read_clk             (read_clk),
    .reset_flags_async    (reset_flags_async),
    .write_submit         (write_submit),
    .read_remove          (read_remove),
    .write_capture_data   (write_capture_data),
    .write_room_available (write_room_available),
    .write_error          (write_error),
    .read_data_available  (read_data_available),
    .read_error           (read_error),
    .write_address        (write_address),
    .read_address         (read_address)
  );

  // ============================================================
  // checks and the per-cycle sample
  // ============================================================

  task automatic check_value(input string name, input int got, input int expected);
    if (got != expected)
    begin
      $display("CHECK FAILED %0s in test %0s: expected 0x%0h, got 0x%0h",
               name, current_test, expected, got);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
      $display("CHECK FAILED %0s in test %0s: expected 0x%0h, got 0x%0h",
               name, current_test, expected, got);
      error_count++;
    end
  endtask

  // called at the falling edge, where every DUT output has settled
  task automatic sample_outputs();
    logic accept_write;
    logic accept_read;
    int occupancy;
    sampled_room = write_room_available;
    sampled_data = read_data_available;
    check_bit("write_error", write_error, pending_write_error);
    check_bit("read_error", read_error, pending_read_error);
    if (write_error)
      test_errors++;
    if (read_error)
      test_errors++;
    // storage captures exactly when a submit meets room
    check_bit("write_capture_data", write_capture_data, write_submit & sampled_room);
    // each address names the entry after all accepted operations so far
    check_value("write_address", int'(write_address), wr_total % fifo_flags_pkg::FIFO_DEPTH);
    check_value("read_address", int'(read_address), rd_total % fifo_flags_pkg::FIFO_DEPTH);
    accept_write = write_submit & sampled_room;
    accept_read = read_remove & sampled_data;
    pending_write_error = write_submit & ~sampled_room;
    pending_read_error = read_remove & ~sampled_data;
    if (accept_write)
      wr_total++;
    if (accept_read)
      rd_total++;
    occupancy = wr_total - rd_total;
    if (occupancy < 0 || occupancy > fifo_flags_pkg::FIFO_DEPTH)
    begin
      $display("model occupancy %0d left the range 0 to %0d in test %0s",
               occupancy, fifo_flags_pkg::FIFO_DEPTH, current_test);
      error_count++;
    end
  endtask

  // ============================================================
  // stimulus
  // ============================================================

  task automatic drive_cycle(input logic submit, input logic remove);
    @(posedge read_clk);
    write_submit <= submit;
    read_remove  <= remove;
    @(negedge read_clk);
    sample_outputs();
  endtask

  task automatic apply_reset(input int hold_cycles);
    @(posedge read_clk);
    reset_flags_async <= 1'b1;
    write_submit      <= 1'b0;
    read_remove       <= 1'b0;
    repeat (hold_cycles) @(posedge read_clk);
    reset_flags_async <= 1'b0;
    wr_total = 0;
    rd_total = 0;
    pending_write_error = 1'b0;
    pending_read_error = 1'b0;
    @(negedge read_clk);
    // an empty buffer with room and quiet error flags
    check_value("write_address", int'(write_address), 0);
    check_value("read_address", int'(read_address), 0);
    check_bit("write_room_available", write_room_available, 1'b1);
    check_bit("read_data_available", read_data_available, 1'b0);
    check_bit("write_error", write_error, 1'b0);
    check_bit("read_error", read_error, 1'b0);
    check_bit("write_capture_data", write_capture_data, 1'b0);
  endtask

  // idle until one flag reaches the wanted level, or give up
  task automatic wait_for_flag(input bit data_side, input logic level, input string flag_name);
    int waited;
    logic seen;
    waited = 0;
    seen = data_side ? read_data_available : write_room_available;
    while (seen !== level && waited < wait_limit)
    begin
      drive_cycle(1'b0, 1'b0);
      waited++;
      seen = data_side ? read_data_available : write_room_available;
    end
    if (seen !== level)
    begin
      $display("timeout in test %0s: %0s did not reach %0d within %0d cycles",
               current_test, flag_name, level, wait_limit);
      timed_out = 1'b1;
      error_count++;
    end
  endtask

  // back-to-back requests on one side, each checked for the flag it met
  task automatic run_burst(input bit write_side, input int cycles, input logic expect_flag);
    for (int i = 0; i < cycles; i++)
    begin
      drive_cycle(write_side, !write_side);
      if (write_side)
        check_bit("write_room_available", sampled_room, expect_flag);
      else
        check_bit("read_data_available", sampled_data, expect_flag);
    end
  endtask

  task automatic run_random(input int cycles);
    logic [31:0] rnd;
    for (int i = 0; i < cycles; i++)
    begin
      rnd = $random(seed);
      drive_cycle(rnd[0], rnd[1]);
    end
  endtask

  function automatic op_kind_t decode_op(input name_t name);
    op_kind_t kind;
    if (name == name_t'("reset"))
      kind = OP_RESET;
    else if (name == name_t'("fill"))
      kind = OP_FILL;
    else if (name == name_t'("overflow"))
      kind = OP_OVERFLOW;
    else if (name == name_t'("drain"))
      kind = OP_DRAIN;
    else if (name == name_t'("underflow"))
      kind = OP_UNDERFLOW;
    else if (name == name_t'("random"))
      kind = OP_RANDOM;
    else
      kind = OP_UNKNOWN;
    return kind;
  endfunction

  // ============================================================
  // one test line
  // ============================================================

  task automatic run_test(input name_t op_name, input int count, input int exp_wa,
                          input int exp_ra, input int exp_err);
    int errors_before;
    int occupancy;
    errors_before = error_count;
    test_errors = 0;
    current_test = op_name;
    tests_run++;
    case (decode_op(op_name))
      OP_RESET:
        apply_reset(count);
      OP_FILL:
      begin
        wait_for_flag(1'b0, 1'b1, "write_room_available");
        if (!timed_out)
          run_burst(1'b1, count, 1'b1);
      end
      OP_OVERFLOW:
      begin
        wait_for_flag(1'b0, 1'b0, "write_room_available");
        if (!timed_out)
          run_burst(1'b1, count, 1'b0);
      end
      OP_DRAIN:
      begin
        wait_for_flag(1'b1, 1'b1, "read_data_available");
        if (!timed_out)
          run_burst(1'b0, count, 1'b1);
      end
      OP_UNDERFLOW:
      begin
        wait_for_flag(1'b1, 1'b0, "read_data_available");
        if (!timed_out)
          run_burst(1'b0, count, 1'b0);
      end
      OP_RANDOM:
        run_random(count);
      default:
      begin
        $display("unknown operation %0s in the test file", op_name);
        error_count++;
      end
    endcase
    if (!timed_out)
    begin
      // let both pointer crossings catch up, so the flags are exact again
      repeat (fifo_flags_pkg::SYNC_STAGES + 1) drive_cycle(1'b0, 1'b0);
      occupancy = wr_total - rd_total;
      check_bit("read_data_available", read_data_available, occupancy > 0);
      check_bit("write_room_available", write_room_available,
                occupancy < fifo_flags_pkg::FIFO_DEPTH);
      if (exp_wa >= 0)
        check_value("write_address", int'(write_address), exp_wa);
      if (exp_ra >= 0)
        check_value("read_address", int'(read_address), exp_ra);
      if (exp_err >= 0 && test_errors != exp_err)
      begin
        $display("test %0s saw %0d error pulses where %0d were expected",
                 op_name, test_errors, exp_err);
        error_count++;
      end
    end
    if (error_count == errors_before)
    begin
      tests_passed++;
      $display("test %0d %0s (%0d): passed", tests_run, op_name, count);
    end
    else
    begin
      $display("test %0d %0s (%0d): failed with %0d errors",
               tests_run, op_name, count, error_count - errors_before);
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================

  initial
  begin
    int fd;
    int code;
    bit done;
    name_t op_name;
    logic [8*120-1:0] line_rest;
    int count;
    int exp_wa;
    int exp_ra;
    int exp_err;
    reset_flags_async <= 1'b1;
    write_submit      <= 1'b0;
    read_remove       <= 1'b0;
    done = 1'b0;
    fd = $fopen("dv/fifo_flags_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test file dv/fifo_flags_tests.txt");
      error_count++;
      done = 1'b1;
    end
    while (!done && !timed_out)
    begin
      code = $fscanf(fd, "%s", op_name);
      if (code != 1)
        done = 1'b1;
      else if (op_name == name_t'("#"))
        // comment line, drop the rest of it
        code = $fgets(line_rest, fd);
      else
      begin
        code = $fscanf(fd, "%d %d %d %d", count, exp_wa, exp_ra, exp_err);
        if (code != 4)
        begin
          $display("test line for %0s is missing values", op_name);
          error_count++;
          done = 1'b1;
        end
        else
          run_test(op_name, count, exp_wa, exp_ra, exp_err);
      end
    end
    if (fd != 0)
      $fclose(fd);
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_passed, tests_run - tests_passed, error_count);
    if (error_count == 0 && tests_run > 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/fifo_flags_top.sv ====
// fifo flag controller top: links the write and read controls through two pointer synchronizers
module fifo_flags_top (
  input  logic                       read_clk,
  input  logic                       reset_flags_async,
  input  logic                       write_submit,
  input  logic                       read_remove,
  output logic                       write_capture_data,
  output logic                       write_room_available,
  output logic                       write_error,
  output logic                       read_data_available,
  output logic                       read_error,
  output fifo_flags_pkg::fifo_addr_t write_address,
  output fifo_flags_pkg::fifo_addr_t read_address
);

  // raw pointers from each side and their synchronized copies
  fifo_flags_pkg::grey_ptr_t write_ptr;
  fifo_flags_pkg::grey_ptr_t read_ptr;
  fifo_flags_pkg::grey_ptr_t synced_write_ptr;
  fifo_flags_pkg::grey_ptr_t synced_read_ptr;

  // ============================================================
  // write side
  // ============================================================

  write_flag_ctrl u_write_ctrl (
    .read_clk             (read_clk),
    .reset_flags_async    (reset_flags_async),
    .write_submit         (write_submit),
    .synced_read_ptr      (synced_read_ptr),
    .write_ptr            (write_ptr),
    .write_address        (write_address),
    .write_capture_data   (write_capture_data),
    .write_room_available (write_room_available),
    .write_error          (write_error)
  );

  // ============================================================
  // pointer crossings
  // ============================================================

  // write pointer toward the read side, where it sets data available
  pointer_sync u_write_ptr_sync (
    .read_clk          (read_clk),
    .reset_flags_async (reset_flags_async),
    .ptr_in            (write_ptr),
    .ptr_out           (synced_write_ptr)
  );

  // read pointer back toward the write side, where it frees room
  pointer_sync u_read_ptr_sync (
    .read_clk          (read_clk),
    .reset_flags_async (reset_flags_async),
    .ptr_in            (read_ptr),
    .ptr_out           (synced_read_ptr)
  );

  // ============================================================
  // read side
  // ============================================================

  read_flag_ctrl u_read_ctrl (
    .read_clk            (read_clk),
    .reset_flags_async   (reset_flags_async),
    .read_remove         (read_remove),
    .synced_write_ptr    (synced_write_ptr),
    .read_ptr            (read_ptr),
    .read_address        (read_address),
    .read_data_available (read_data_available),
    .read_error          (read_error)
  );

endmodule

// ==== hdl/read_flag_ctrl.sv ====
// read-side flag control: keeps the read grey pointer and address, and raises data and error flags
module read_flag_ctrl (
  input  logic                      read_clk,
  input  logic                      reset_flags_async,
  input  logic                      read_remove,
  input  fifo_flags_pkg::grey_ptr_t synced_write_ptr,
  output fifo_flags_pkg::grey_ptr_t read_ptr,
  output fifo_flags_pkg::fifo_addr_t read_address,
  output logic                      read_data_available,
  output logic                      read_error
);

  // ============================================================
  // data detection
  // ============================================================

  // an accepted remove in this cycle
  logic accept_remove;

  // a remove attempted on an empty buffer
  logic refused_remove;

  // equal pointers mean empty
  // the write pointer seen here lags by SYNC_STAGES cycles, so a fresh
  // write shows up late and data is never reported before it exists
  assign read_data_available = (read_ptr != synced_write_ptr);

  assign accept_remove = read_remove & read_data_available;
  assign refused_remove = read_remove & ~read_data_available;

  // ============================================================
  // pointer, address and error registers
  // ============================================================

  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      read_ptr     <= '0;
      read_address <= '0;
      read_error   <= 1'b0;
    end
    else
    begin
      // the entry at read_address is consumed, move to the next one
      if (accept_remove)
      begin
        read_ptr     <= fifo_flags_pkg::grey_inc(read_ptr);
        read_address <= fifo_flags_pkg::addr_inc(read_address);
      end
      // one-cycle error pulse after a remove on an empty buffer
      read_error <= refused_remove;
    end
  end

  // ============================================================
  // checks
  // ============================================================

  // data shown without a remove must still be there next cycle
  // only the write pointer can move then, and the room flag keeps it
  // from wrapping all the way round onto the read pointer
  a_data_kept_while_idle: assert property (
    @(posedge read_clk) disable iff (reset_flags_async)
    read_data_available && !read_remove |=> read_data_available
  );

endmodule

// ==== hdl/pointer_sync.sv ====
// pointer synchronizer: carries one grey pointer across to the other side through a flop chain
module pointer_sync (
  input  logic                      read_clk,
  input  logic                      reset_flags_async,
  input  fifo_flags_pkg::grey_ptr_t ptr_in,
  output fifo_flags_pkg::grey_ptr_t ptr_out
);

  // ============================================================
  // synchronizer chain
  // ============================================================

  // stage 0 takes the raw pointer, the last stage feeds the other side
  // with both sides on one clock the chain gives a fixed latency
  fifo_flags_pkg::grey_ptr_t [fifo_flags_pkg::SYNC_STAGES-1:0] sync_stage;

  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      // an all-zero pointer on both sides means an empty buffer
      sync_stage <= '0;
    end
    else
    begin
      sync_stage[0] <= ptr_in;
      for (int i = 1; i < fifo_flags_pkg::SYNC_STAGES; i++)
      begin
        sync_stage[i] <= sync_stage[i-1];
      end
    end
  end

  assign ptr_out = sync_stage[fifo_flags_pkg::SYNC_STAGES-1];

  // ============================================================
  // checks
  // ============================================================

  // the crossing is only safe if the source moves at most one grey step
  // per cycle, so at most one bit may differ from the previous cycle
  a_one_step: assert property (
    @(posedge read_clk) disable iff (reset_flags_async)
    $countones(ptr_in ^ $past(ptr_in)) <= 1
  );

endmodule

// ==== hdl/write_flag_ctrl.sv ====
// write-side flag control: keeps the write grey pointer and address, and raises room and error flags
module write_flag_ctrl (
  input  logic                      read_clk,
  input  logic                      reset_flags_async,
  input  logic                      write_submit,
  input  fifo_flags_pkg::grey_ptr_t synced_read_ptr,
  output fifo_flags_pkg::grey_ptr_t write_ptr,
  output fifo_flags_pkg::fifo_addr_t write_address,
  output logic                      write_capture_data,
  output logic                      write_room_available,
  output logic                      write_error
);

  // ============================================================
  // room detection
  // ============================================================

  // the pointer value this side would move to on an accepted write
  fifo_flags_pkg::grey_ptr_t next_write_ptr;

  // true in a cycle where a submit is refused for lack of room
  logic refused_submit;

  assign next_write_ptr = fifo_flags_pkg::grey_inc(write_ptr);

  // the buffer is full when one more step would land on the read pointer
  // the read pointer seen here is SYNC_STAGES cycles old, so the flag
  // can only under-report room, never over-report it
  assign write_room_available = (next_write_ptr != synced_read_ptr);

  // storage captures the word in the same cycle the submit is accepted
  assign write_capture_data = write_submit & write_room_available;

  assign refused_submit = write_submit & ~write_room_available;

  // ============================================================
  // pointer, address and error registers
  // ============================================================

  always_ff @(posedge read_clk or posedge reset_flags_async)
  begin
    if (reset_flags_async)
    begin
      write_ptr     <= '0;
      write_address <= '0;
      write_error   <= 1'b0;
    end
    else
    begin
      // pointer and address step together on each accepted write
      if (write_capture_data)
      begin
        write_ptr     <= next_write_ptr;
        write_address <= fifo_flags_pkg::addr_inc(write_address);
      end
      // the error flag lasts exactly one cycle after each refused submit
      write_error <= refused_submit;
    end
  end

  // ============================================================
  // checks
  // ============================================================

  // room shown without a submit must still be there next cycle
  // only the read pointer can move then, and it never runs past this write pointer
  a_room_kept_while_idle: assert property (
    @(posedge read_clk) disable iff (reset_flags_async)
    write_room_available && !write_submit |=> write_room_available
  );

endmodule

// ==== hdl/fifo_flags_pkg.sv ====
// fifo flag package: depth, pointer and address widths, and the grey and address step functions
package fifo_flags_pkg;

  // ============================================================
  // sizes
  // ============================================================

  // number of storage entries behind the flag controller
  localparam int FIFO_DEPTH = 7;

  // a 3-bit grey pointer has 8 codes, so it can tell 0 through 7 entries apart
  // and the buffer needs only 7 storage locations
  localparam int PTR_WIDTH = 3;

  // the storage address counts 0 to 6 and then wraps
  localparam int ADDR_WIDTH = 3;

  // flops in each pointer synchronizer chain
  // this is also the fixed latency, in cycles, of each crossing
  localparam int SYNC_STAGES = 2;

  // ============================================================
  // types
  // ============================================================

  typedef logic [PTR_WIDTH-1:0] grey_ptr_t;
  typedef logic [ADDR_WIDTH-1:0] fifo_addr_t;

  // ============================================================
  // step functions
  // ============================================================

  // next code in the 3-bit grey sequence
  // only one bit flips per step, which keeps the synchronized copy coherent
  function automatic grey_ptr_t grey_inc(input grey_ptr_t ptr);
    grey_ptr_t next_ptr;
    case (ptr)
      3'b000: next_ptr = 3'b001;
      3'b001: next_ptr = 3'b011;
      3'b011: next_ptr = 3'b010;
      3'b010: next_ptr = 3'b110;
      3'b110: next_ptr = 3'b111;
      3'b111: next_ptr = 3'b101;
      3'b101: next_ptr = 3'b100;
      3'b100: next_ptr = 3'b000;
      // every 3-bit code is covered above, this only keeps the logic closed
      default: next_ptr = 3'b000;
    endcase
    return next_ptr;
  endfunction

  // next storage address, modulo the depth
  // the pointer wraps every 8 steps but the address every 7
  function automatic fifo_addr_t addr_inc(input fifo_addr_t addr);
    fifo_addr_t next_addr;
    if (addr == fifo_addr_t'(FIFO_DEPTH - 1))
      next_addr = '0;
    else
      next_addr = addr + fifo_addr_t'(1);
    return next_addr;
  endfunction

endpackage
